// ==== bench/tb_vacc.sv ====
`timescale 1ns/10ps

module tb_vacc;
    import vacc_pkg::*;

    localparam int VECTOR_LEN    = 64;
    localparam int OUT_DEPTH     = 64;
    localparam int NUM_ROWS      = 5;
    localparam int IDLE_BEATS    = 2 * VECTOR_LEN;
    localparam int STARVE_CYCLES = 8 * VECTOR_LEN;

    localparam logic [1:0] SINK_PROMPT = 2'd0;
    localparam logic [1:0] SINK_SLOW   = 2'd1;
    localparam logic [1:0] SINK_STARVE = 2'd2;

    // one row of the test table
    typedef struct packed {
        frames_t    len;
        logic [7:0] integrations;
        logic       gapped;
        logic [1:0] sink;
    } test_row_t;

    logic         clk;
    logic         reset;
    sample_beat_t in_beat;
    cfg_wr_t      cfg;
    logic         credit;
    acc_beat_t    out_beat;
    logic         overflow;

    test_row_t    rows [NUM_ROWS];
    sample_t      frame_buf [VECTOR_LEN];
    acc_t         model_sum [VECTOR_LEN];
    acc_t         exp_data [$];
    logic         exp_last [$];
    logic         model_primed;
    logic         integ_start;
    int           frame_idx;
    int           active_frames;
    logic [31:0]  stim_state;
    logic [31:0]  sink_state;
    logic [1:0]   sink_mode = SINK_PROMPT;
    logic         starve_row = 1'b0;
    logic         out_idle = 1'b1;
    int           starve_until = 0;
    int           cycle_count = 0;
    int           cycle_limit = 0;
    int           beats_seen = 0;
    int           credits_back = 0;
    int           owed = 0;
    int           starved_matches = 0;

    vacc_top #(
        .VECTOR_LEN (VECTOR_LEN),
        .OUT_DEPTH  (OUT_DEPTH)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .in_beat  (in_beat),
        .cfg      (cfg),
        .credit   (credit),
        .out_beat (out_beat),
        .overflow (overflow)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic end_failed();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_acc(input acc_t got, input acc_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            end_failed();
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %b expected %b", $time, what, got, exp);
            end_failed();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %b expected %b", $time, what, got, exp);
            end_failed();
        end
    endtask

    // enable rising starts a fresh integration with the new length
    task automatic model_restart(input frames_t len);
        integ_start   = 1'b1;
        frame_idx     = 0;
        active_frames = (len == '0) ? 1 : int'(len);
    endtask

    // first frame of an integration dumps the old sums and replaces them
    task automatic model_frame();
        int k;
        if (integ_start) begin
            if (model_primed) begin
                for (k = 0; k < VECTOR_LEN; k++) begin
                    exp_data.push_back(model_sum[k]);
                    exp_last.push_back(k == VECTOR_LEN - 1);
                end
            end
            for (k = 0; k < VECTOR_LEN; k++) begin
                model_sum[k] = acc_t'(frame_buf[k]);
            end
            model_primed = 1'b1;
        end else begin
            for (k = 0; k < VECTOR_LEN; k++) begin
                model_sum[k] = model_sum[k] + acc_t'(frame_buf[k]);
            end
        end
        frame_idx++;
        integ_start = (frame_idx == active_frames);
        if (integ_start) begin
            frame_idx = 0;
        end
    endtask

    task automatic write_cfg(input logic addr, input frames_t value);
        @(negedge clk);
        cfg.we    = 1'b1;
        cfg.addr  = addr;
        cfg.wdata = value;
        @(negedge clk);
        cfg = '0;
    endtask

    task automatic send_frame(input logic gapped);
        int k;
        int gap;
        for (k = 0; k < VECTOR_LEN; k++) begin
            stim_state   = xorshift32(stim_state);
            frame_buf[k] = stim_state[15:0];
        end
        model_frame();
        for (k = 0; k < VECTOR_LEN; k++) begin
            if (gapped) begin
                stim_state = xorshift32(stim_state);
                gap        = int'(stim_state[1:0]);
                repeat (gap) begin
                    @(negedge clk);
                    in_beat = '0;
                end
            end
            @(negedge clk);
            in_beat.valid = 1'b1;
            in_beat.data  = frame_buf[k];
        end
    endtask

    task automatic run_row(input test_row_t row);
        int frames;
        // one extra frame flushes the last integration out
        frames = int'(row.len) * int'(row.integrations) + 1;
        write_cfg(CFG_ADDR_EN, frames_t'(0));
        write_cfg(CFG_ADDR_LEN, row.len);
        sink_mode = row.sink;
        if (row.sink == SINK_STARVE) begin
            starve_row   = 1'b1;
            starve_until = cycle_count + STARVE_CYCLES;
        end
        write_cfg(CFG_ADDR_EN, frames_t'(1));
        model_restart(row.len);
        repeat (frames) begin
            send_frame(row.gapped);
        end
        @(negedge clk);
        in_beat = '0;
        if (row.sink == SINK_STARVE) begin
            do @(posedge clk);
            while (!(cycle_count >= starve_until && owed == 0 && out_idle));
            check_flag(overflow, 1'b1, "overflow after starving the sink");
            check_flag(starved_matches >= VECTOR_LEN, 1'b1, "whole vector before the drop");
        end else begin
            do @(posedge clk);
            while (exp_data.size() != 0 || owed != 0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            end_failed();
        end
    end

    // sink side, samples out_beat and returns credits
    initial begin : sink_proc
        acc_t exp_d;
        logic exp_l;
        logic give;
        credit     = 1'b0;
        sink_state = xorshift32(32'd12);
        forever begin
            @(negedge clk);
            give = 1'b0;
            if (!starve_row) begin
                check_flag(overflow, 1'b0, "overflow flag");
            end
            out_idle = !out_beat.valid;
            if (out_beat.valid) begin
                check_flag(beats_seen < credits_back + OUT_DEPTH, 1'b1, "beat beyond credits");
                beats_seen++;
                owed++;
                if (exp_data.size() != 0) begin
                    exp_d = exp_data.pop_front();
                    exp_l = exp_last.pop_front();
                    // after a drop the stream no longer lines up with the model
                    if (!overflow) begin
                        check_acc(out_beat.data, exp_d, "accumulated element");
                        check_last(out_beat.last, exp_l, "last flag");
                        if (starve_row) begin
                            starved_matches++;
                        end
                    end
                end else if (!starve_row) begin
                    $display("an output beat arrived with no result expected at %0t ns", $time);
                    end_failed();
                end
            end
            sink_state = xorshift32(sink_state);
            case (sink_mode)
                SINK_PROMPT: give = (owed > 0);
                SINK_SLOW:   give = (owed > 0) && sink_state[0];
                default:     give = (owed > 0) && (cycle_count >= starve_until);
            endcase
            credit = give;
            if (give) begin
                owed--;
                credits_back++;
            end
        end
    end

    initial begin
        int r;
        rows[0] = '{len: 16'd1, integrations: 8'd3, gapped: 1'b0, sink: SINK_PROMPT};
        rows[1] = '{len: 16'd4, integrations: 8'd2, gapped: 1'b0, sink: SINK_PROMPT};
        rows[2] = '{len: 16'd3, integrations: 8'd2, gapped: 1'b1, sink: SINK_PROMPT};
        rows[3] = '{len: 16'd2, integrations: 8'd3, gapped: 1'b1, sink: SINK_SLOW};
        rows[4] = '{len: 16'd1, integrations: 8'd5, gapped: 1'b0, sink: SINK_STARVE};

        // worst case of four cycles per beat, with four times margin
        cycle_limit = 16 + IDLE_BEATS;
        for (r = 0; r < NUM_ROWS; r++) begin
            cycle_limit += (int'(rows[r].len) * int'(rows[r].integrations) + 1)
                           * VECTOR_LEN * 4;
        end
        cycle_limit = 4 * cycle_limit + STARVE_CYCLES;

        stim_state   = 32'd12;
        model_primed = 1'b0;
        integ_start  = 1'b1;
        frame_idx    = 0;
        in_beat      = '0;
        cfg          = '0;
        reset        = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // beats before enable must be ignored
        repeat (IDLE_BEATS) begin
            @(negedge clk);
            stim_state    = xorshift32(stim_state);
            in_beat.valid = 1'b1;
            in_beat.data  = stim_state[15:0];
        end
        @(negedge clk);
        in_beat = '0;

        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== project.f ====
rtl/vacc_pkg.sv
rtl/acc_ram.sv
rtl/vector_accumulator.sv
rtl/integ_ctrl.sv
rtl/credit_out.sv
rtl/vacc_top.sv
bench/tb_vacc.sv

// ==== rtl/acc_ram.sv ====
`timescale 1ns/10ps

module acc_ram #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  vacc_pkg::acc_t           wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output vacc_pkg::acc_t           rdata
);
    import vacc_pkg::*;

    acc_t mem [DEPTH];
    acc_t rd_q;

    // array read is registered, maps onto a block RAM
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rd_q <= mem[raddr];
    end

    // output register, second read cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            rdata <= rd_q;
        end
    end

endmodule

// ==== rtl/credit_out.sv ====
`timescale 1ns/10ps

module credit_out #(
    parameter int OUT_DEPTH = 64
) (
    input  logic                clk,
    input  logic                reset,
    input  vacc_pkg::acc_beat_t dump_beat,
    input  logic                credit,
    output vacc_pkg::acc_beat_t out_beat,
    output logic                overflow
);
    import vacc_pkg::*;

    localparam int               PTR_W     = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int               CNT_W     = $clog2(OUT_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(OUT_DEPTH);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(OUT_DEPTH - 1);

    acc_t                 data_mem [OUT_DEPTH];
    logic [OUT_DEPTH-1:0] last_mem;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     fill;
    logic [CNT_W-1:0]     credit_cnt;
    logic                 dropping;
    logic                 full;
    logic                 empty;
    logic                 refuse;
    logic                 push;
    logic                 send;

    function automatic logic [PTR_W-1:0] next_slot(input logic [PTR_W-1:0] p);
        return (p == LAST_SLOT) ? '0 : p + 1'b1;
    endfunction

    assign full   = (fill == FULL_CNT);
    assign empty  = (fill == '0);
    // once a beat is refused the rest of its vector goes too
    assign refuse = dump_beat.valid && (dropping || full);
    assign push   = dump_beat.valid && !refuse;
    assign send   = !empty && (credit_cnt != '0);

    assign out_beat.valid = send;
    assign out_beat.last  = last_mem[rd_ptr];
    assign out_beat.data  = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= dump_beat.data;
            last_mem[wr_ptr] <= dump_beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            credit_cnt <= FULL_CNT;
            dropping   <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_slot(wr_ptr);
            end
            if (send) begin
                rd_ptr <= next_slot(rd_ptr);
            end
            if (push && !send) begin
                fill <= fill + 1'b1;
            end else if (send && !push) begin
                fill <= fill - 1'b1;
            end
            // credit back and send in one cycle cancel out
            if (credit && !send) begin
                credit_cnt <= credit_cnt + 1'b1;
            end else if (send && !credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end
            if (refuse) begin
                overflow <= 1'b1;
                dropping <= !dump_beat.last;
            end
        end
    end

    // sink returned more credits than it has slots
    a_credit_max : assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= FULL_CNT)
        else $error("credit count above buffer depth of sink");

    a_credit_floor : assert property (@(posedge clk) disable iff (reset)
        (credit_cnt == '0 && !credit) |=> (credit_cnt == '0))
        else $error("credit count moved at zero without a credit");

endmodule

// ==== rtl/integ_ctrl.sv ====
`timescale 1ns/10ps

module integ_ctrl #(
    parameter int VECTOR_LEN = 64
) (
    input  logic                   clk,
    input  logic                   reset,
    input  vacc_pkg::cfg_wr_t      cfg,
    input  vacc_pkg::sample_beat_t in_beat,
    output vacc_pkg::sample_beat_t sample_en,
    output logic                   new_acc
);
    import vacc_pkg::*;

    localparam int                ELEM_W    = $clog2(VECTOR_LEN);
    localparam logic [ELEM_W-1:0] LAST_ELEM = ELEM_W'(VECTOR_LEN - 1);

    frames_t           int_len;
    frames_t           active_len;
    frames_t           frame_cnt;
    frames_t           last_frame;
    logic              enable;
    logic [ELEM_W-1:0] elem_cnt;
    logic              frame_end;
    logic              integ_end;
    logic              enable_rise;

    // sampler cannot stall, beats are simply blocked while disabled
    assign sample_en.valid = in_beat.valid & enable;
    assign sample_en.data  = in_beat.data;

    assign last_frame  = (active_len == '0) ? '0 : active_len - 1'b1;
    assign frame_end   = sample_en.valid && (elem_cnt == LAST_ELEM);
    assign integ_end   = frame_end && (frame_cnt == last_frame);
    assign enable_rise = cfg.we && (cfg.addr == CFG_ADDR_EN) && cfg.wdata[0] && !enable;

    always_ff @(posedge clk) begin
        if (reset) begin
            int_len <= frames_t'(1);
            enable  <= 1'b0;
        end else if (cfg.we) begin
            if (cfg.addr == CFG_ADDR_LEN) begin
                int_len <= cfg.wdata;
            end else begin
                enable <= cfg.wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            elem_cnt   <= '0;
            frame_cnt  <= '0;
            active_len <= frames_t'(1);
            new_acc    <= 1'b0;
        end else if (enable_rise) begin
            // first frame after enable starts a fresh integration
            elem_cnt   <= '0;
            frame_cnt  <= '0;
            active_len <= int_len;
            new_acc    <= 1'b1;
        end else begin
            if (sample_en.valid) begin
                elem_cnt <= frame_end ? '0 : elem_cnt + 1'b1;
            end
            if (frame_end) begin
                frame_cnt <= integ_end ? '0 : frame_cnt + 1'b1;
            end
            // new length only picked up at the boundary
            if (integ_end) begin
                active_len <= int_len;
                new_acc    <= 1'b1;
            end else if (frame_end) begin
                new_acc <= 1'b0;
            end
        end
    end

    a_new_acc_frame_start : assert property (@(posedge clk) disable iff (reset)
        $rose(new_acc) |-> (elem_cnt == '0))
        else $error("new_acc raised inside a frame");

endmodule

// ==== rtl/vacc_pkg.sv ====
package vacc_pkg;

    // one unsigned power sample from the spectrometer front end
    typedef logic [15:0] sample_t;

    // accumulated element, wide enough for 65536 frames of full-scale samples
    typedef logic [31:0] acc_t;

    // integration length in frames, 0 behaves as 1
    typedef logic [15:0] frames_t;

    // input beat, one vector element per valid
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_beat_t;

    // result beat, last marks element VECTOR_LEN-1
    typedef struct packed {
        logic valid;
        logic last;
        acc_t data;
    } acc_beat_t;

    // register write port
    typedef struct packed {
        logic    we;
        logic    addr;
        frames_t wdata;
    } cfg_wr_t;

    // register map
    localparam logic CFG_ADDR_LEN = 1'b0;
    localparam logic CFG_ADDR_EN  = 1'b1;

endpackage

// ==== rtl/vacc_top.sv ====
`timescale 1ns/10ps

module vacc_top #(
    parameter int VECTOR_LEN = 64,
    parameter int OUT_DEPTH  = 64
) (
    input  logic                   clk,
    input  logic                   reset,
    input  vacc_pkg::sample_beat_t in_beat,
    input  vacc_pkg::cfg_wr_t      cfg,
    input  logic                   credit,
    output vacc_pkg::acc_beat_t    out_beat,
    output logic                   overflow
);
    import vacc_pkg::*;

    sample_beat_t sample_en;
    logic         new_acc;
    acc_beat_t    dump_beat;

    integ_ctrl #(
        .VECTOR_LEN (VECTOR_LEN)
    ) ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .in_beat   (in_beat),
        .sample_en (sample_en),
        .new_acc   (new_acc)
    );

    vector_accumulator #(
        .VECTOR_LEN (VECTOR_LEN)
    ) vacc0 (
        .clk       (clk),
        .reset     (reset),
        .sample_en (sample_en),
        .new_acc   (new_acc),
        .dump_beat (dump_beat)
    );

    // results cross to the sink under credit control
    credit_out #(
        .OUT_DEPTH (OUT_DEPTH)
    ) out0 (
        .clk       (clk),
        .reset     (reset),
        .dump_beat (dump_beat),
        .credit    (credit),
        .out_beat  (out_beat),
        .overflow  (overflow)
    );

endmodule

// ==== rtl/vector_accumulator.sv ====
`timescale 1ns/10ps

module vector_accumulator #(
    parameter int VECTOR_LEN = 64
) (
    input  logic                   clk,
    input  logic                   reset,
    input  vacc_pkg::sample_beat_t sample_en,
    input  logic                   new_acc,
    output vacc_pkg::acc_beat_t    dump_beat
);
    import vacc_pkg::*;

    localparam int               PTR_W    = $clog2(VECTOR_LEN);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(VECTOR_LEN - 1);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [2:0]       valid_d;
    logic [1:0]       add_zero_d;
    logic [1:0]       dump_d;
    logic [1:0]       last_d;
    logic             add_zero;
    logic             primed;
    logic             beat_first;
    logic             beat_last;
    logic             beat_mode;
    sample_t          sample_d [2];
    acc_t             rd_word;
    acc_t             word_hold;
    acc_t             acc_wr;
    logic             dump_valid;
    logic             dump_last;
    acc_t             dump_data;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == LAST_IDX) ? '0 : p + 1'b1;
    endfunction

    // rd_ptr runs one element ahead of the beat being taken
    assign beat_first = (rd_ptr == PTR_W'(1));
    assign beat_last  = (rd_ptr == '0);

    // the mode is sampled at element 0 and held for the whole frame
    assign beat_mode = beat_first ? new_acc : add_zero;

    acc_ram #(
        .DEPTH (VECTOR_LEN)
    ) ram0 (
        .clk   (clk),
        .reset (reset),
        .we    (valid_d[2]),
        .waddr (wr_ptr),
        .wdata (acc_wr),
        .raddr (rd_ptr),
        .rdata (rd_word)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr     <= PTR_W'(1);
            wr_ptr     <= '0;
            valid_d    <= '0;
            add_zero_d <= '0;
            dump_d     <= '0;
            last_d     <= '0;
            add_zero   <= 1'b0;
            primed     <= 1'b0;
        end else begin
            valid_d    <= {valid_d[1:0], sample_en.valid};
            add_zero_d <= {add_zero_d[0], beat_mode};
            // no dump until the RAM holds one complete integration
            dump_d     <= {dump_d[0], beat_mode & primed};
            last_d     <= {last_d[0], beat_last};
            if (sample_en.valid) begin
                rd_ptr   <= next_ptr(rd_ptr);
                add_zero <= beat_mode;
                if (beat_mode && beat_last) begin
                    primed <= 1'b1;
                end
            end
            if (valid_d[2]) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
        end
    end

    // word for element k is read during beat k-1, so it sits on rd_word
    // when beat k-1 reaches stage 2; held here until beat k gets there
    always_ff @(posedge clk) begin
        sample_d[0] <= sample_en.data;
        sample_d[1] <= sample_d[0];
        if (valid_d[1]) begin
            word_hold <= rd_word;
            if (add_zero_d[1]) begin
                acc_wr <= acc_t'(sample_d[1]);
            end else begin
                acc_wr <= word_hold + acc_t'(sample_d[1]);
            end
            dump_data <= word_hold;
        end
    end

    // dump leaves together with the RAM write, 3 cycles after the beat
    always_ff @(posedge clk) begin
        if (reset) begin
            dump_valid <= 1'b0;
            dump_last  <= 1'b0;
        end else begin
            dump_valid <= valid_d[1] & dump_d[1];
            dump_last  <= valid_d[1] & dump_d[1] & last_d[1];
        end
    end

    assign dump_beat.valid = dump_valid;
    assign dump_beat.last  = dump_last;
    assign dump_beat.data  = dump_data;

    // pointers stay one element apart once the pipeline drains
    a_ptr_distance : assert property (@(posedge clk) disable iff (reset)
        (!sample_en.valid && valid_d == '0) |-> (rd_ptr == next_ptr(wr_ptr)))
        else $error("read and write pointers out of step");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the accumulator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_vacc \
    -f project.f \
    -o sim_vacc

# the testbench ends every failing run with $fatal
./obj_dir/sim_vacc
